// File: common/game_pkg.sv
`default_nettype none

package game_pkg;

  localparam int NUM_SPRITES   = 16;
  localparam int NUM_ATTRS     = 8;
  localparam int NUM_REGS      = 32;
  localparam int CANVAS_WIDTH  = 320;
  localparam int CANVAS_HEIGHT = 180;
  localparam int NUM_FRAMES    = 8;
  localparam int PROGRAM_LEN   = 64; // Core halts when the pc reaches this

  localparam int ATTR_HEALTH = 0;
  localparam int ATTR_X      = 1;
  localparam int ATTR_Y      = 2;
  localparam int ATTR_FRAME  = 3;

  typedef logic [31:0]                       word_t;
  typedef logic [35:0]                       instr_t;
  typedef logic [$clog2(NUM_REGS)-1:0]       reg_idx_t;
  typedef logic [$clog2(NUM_SPRITES)-1:0]    sprite_idx_t;
  typedef logic [$clog2(NUM_ATTRS)-1:0]      attr_idx_t;
  typedef logic [$clog2(PROGRAM_LEN)-1:0]    pc_t;
  typedef logic [$clog2(CANVAS_WIDTH)-1:0]   coord_x_t;
  typedef logic [$clog2(CANVAS_HEIGHT)-1:0]  coord_y_t;
  typedef logic [$clog2(NUM_FRAMES)-1:0]     frame_t;

  // Key is {instr[32], instr[6:0]}
  typedef enum logic [7:0] {
    OP_LI     = 8'h37,
    OP_REGIMM = 8'h13,
    OP_REGREG = 8'h33,
    OP_SPLI   = 8'hB7,
    OP_SPIMM  = 8'h93,
    OP_SPREG  = 8'hB3,
    OP_LISP   = 8'hBF,
    OP_BRANCH = 8'h63,
    OP_JAL    = 8'h6F
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_PASS, ALU_ADD, ALU_SUB, ALU_SUB_FLOOR, ALU_SP_SUB_FLOOR,
    ALU_CMP_EQ, ALU_CMP_NE, ALU_CMP_LT, ALU_CMP_GE, ALU_NOP
  } alu_op_e;

  typedef enum logic [2:0] {
    ST_FETCH, ST_RELEASE, ST_EXECUTE, ST_WRITEBACK, ST_HALT
  } core_state_e;

  typedef struct packed {
    alu_op_e     alu_op;
    reg_idx_t    rd;
    reg_idx_t    rs1;
    reg_idx_t    rs2;
    sprite_idx_t sprite;
    attr_idx_t   attr;
    word_t       imm;
    logic        use_imm;      // ALU operand B is imm instead of rs2
    logic        writes_reg;
    logic        writes_sprite;
    logic        reads_sprite;
    logic        is_branch;
    logic        is_jal;
    pc_t         target;
  } dec_op_t;

  typedef struct packed {
    logic        valid;
    sprite_idx_t sprite;
    attr_idx_t   attr;
    word_t       data;
  } sprite_wr_t;

  typedef struct packed {
    logic taken;
    pc_t  target;
  } redirect_t;

  typedef word_t [NUM_ATTRS-1:0] sprite_attrs_t;

endpackage

`default_nettype wire

// File: core/fetch_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_ctrl import game_pkg::*; (
  input  wire             pixel_clk_in,
  input  wire             rst_in,
  input  wire             instr_ack,
  input  wire instr_t     instr_data,
  input  wire redirect_t  redirect,
  output logic            instr_req,
  output pc_t             instr_addr,
  output instr_t          instr,
  output pc_t             pc,
  output core_state_e     state,
  output logic            done
);

  core_state_e state_d;
  logic [$clog2(PROGRAM_LEN):0] pc_next; // One bit wider to see the end

  assign instr_addr = pc;
  assign done = (state == ST_HALT);
  assign pc_next = redirect.taken ? {1'b0, redirect.target} : {1'b0, pc} + 1'b1;

  always_comb begin
    state_d = state;
    case (state)
      ST_FETCH:     if (instr_req && instr_ack) state_d = ST_RELEASE;
      ST_RELEASE:   if (!instr_ack) state_d = ST_EXECUTE; // Wait for ack low
      ST_EXECUTE:   state_d = ST_WRITEBACK;
      ST_WRITEBACK: state_d = (pc_next == PROGRAM_LEN) ? ST_HALT : ST_FETCH;
      default:      state_d = ST_HALT;
    endcase
  end

  always_ff @(posedge pixel_clk_in) begin
    if (rst_in) begin
      state     <= ST_FETCH;
      pc        <= '0;
      instr_req <= 1'b0;
    end else begin
      state     <= state_d;
      instr_req <= (state_d == ST_FETCH);
      if (state == ST_WRITEBACK) begin
        pc <= pc_t'(pc_next);
      end
    end
  end

  always_ff @(posedge pixel_clk_in) begin
    if (state == ST_FETCH && instr_req && instr_ack) begin
      instr <= instr_data;
    end
  end

endmodule

`default_nettype wire

// File: core/instr_decode.sv
`timescale 1ns/1ps
`default_nettype none

module instr_decode import game_pkg::*; (
  input  wire instr_t instr,
  output dec_op_t     op
);

  opcode_e key;

  assign key = opcode_e'({instr[32], instr[6:0]});

  always_comb begin
    op        = '0;
    op.alu_op = ALU_NOP;
    op.rd     = instr[11:7];
    op.rs1    = instr[19:15];
    op.rs2    = instr[24:20];
    op.sprite = instr[10:7];  // Low 4 bits of the 6-bit sprite field
    op.attr   = instr[35:33];

    case (key)
      OP_LI: begin
        op.alu_op     = ALU_PASS;
        op.imm        = word_t'(instr[31:12]);
        op.writes_reg = 1'b1;
      end
      OP_REGIMM: begin
        op.imm     = word_t'(instr[31:20]);
        op.use_imm = 1'b1;
        case (instr[14:12])
          3'd0: begin
            op.alu_op     = ALU_ADD;
            op.writes_reg = 1'b1;
          end
          3'd1: begin
            op.alu_op     = ALU_SUB; // Wraps
            op.writes_reg = 1'b1;
          end
          default: ;
        endcase
      end
      OP_REGREG: begin
        case (instr[31:25])
          7'd0: begin
            op.alu_op     = ALU_ADD;
            op.writes_reg = 1'b1;
          end
          7'd1: begin
            op.alu_op     = ALU_SUB_FLOOR;
            op.writes_reg = 1'b1;
          end
          default: ;
        endcase
      end
      OP_SPLI: begin
        op.alu_op        = ALU_PASS;
        op.imm           = word_t'(instr[31:13]);
        op.writes_sprite = 1'b1;
      end
      OP_SPIMM: begin
        if (instr[14:13] == 2'd0) begin
          op.alu_op        = ALU_ADD; // SPADDI
          op.imm           = word_t'(instr[31:20]);
          op.use_imm       = 1'b1;
          op.writes_sprite = 1'b1;
        end
      end
      OP_SPREG: begin
        if (instr[31:25] == 7'h20) begin
          op.alu_op        = ALU_SP_SUB_FLOOR;
          op.reads_sprite  = 1'b1;
          op.writes_sprite = 1'b1;
        end
      end
      OP_LISP: begin
        op.alu_op       = ALU_PASS;
        op.sprite       = instr[17:14];
        op.reads_sprite = 1'b1;
        op.writes_reg   = 1'b1;
      end
      OP_BRANCH: begin
        op.target = pc_t'({instr[31:25], instr[11:7]});
        case (instr[14:12])
          3'd0: op.alu_op = ALU_CMP_EQ;
          3'd1: op.alu_op = ALU_CMP_NE;
          3'd4: op.alu_op = ALU_CMP_LT;
          3'd5: op.alu_op = ALU_CMP_GE;
          default: ;
        endcase
        op.is_branch = (op.alu_op != ALU_NOP);
      end
      OP_JAL: begin
        op.alu_op     = ALU_PASS;
        op.target     = pc_t'(instr[31:12]);
        op.is_jal     = 1'b1;
        op.writes_reg = 1'b1;
      end
      default: ; // Unknown key stays a NOP
    endcase
  end

endmodule

`default_nettype wire

// File: core/exec_unit.sv
`timescale 1ns/1ps
`default_nettype none

module exec_unit import game_pkg::*; (
  input  wire                pixel_clk_in,
  input  wire                rst_in,
  input  wire core_state_e   state,
  input  wire dec_op_t       op,
  input  wire pc_t           pc,
  input  wire sprite_attrs_t slot_attrs [NUM_SPRITES],
  output redirect_t          redirect,
  output sprite_wr_t         sprite_wr
);

  word_t regs [NUM_REGS];

  word_t rs1_val;
  word_t rs2_val;
  word_t attr_val;
  word_t opnd_b;
  word_t result;
  logic  cond;

  // Registered at the end of EXECUTE
  logic        wb_pending;
  logic        wr_valid;
  logic        taken_q;
  reg_idx_t    wb_rd;
  sprite_idx_t wr_sprite;
  attr_idx_t   wr_attr;
  word_t       res_q;
  pc_t         target_q;

  assign rs1_val  = regs[op.rs1];
  assign rs2_val  = regs[op.rs2];
  assign attr_val = slot_attrs[op.sprite][op.attr];
  assign opnd_b   = op.use_imm ? op.imm : rs2_val;

  always_comb begin
    result = '0;
    cond   = 1'b0;
    case (op.alu_op)
      ALU_PASS: begin
        if (op.is_jal) begin
          result = word_t'(pc) + 32'd1; // Link address
        end else begin
          result = op.reads_sprite ? attr_val : op.imm;
        end
      end
      ALU_ADD:          result = rs1_val + opnd_b;
      ALU_SUB:          result = rs1_val - opnd_b;
      ALU_SUB_FLOOR:    result = (rs1_val < opnd_b) ? '0 : rs1_val - opnd_b;
      ALU_SP_SUB_FLOOR: result = (attr_val < rs1_val) ? '0 : attr_val - rs1_val;
      ALU_CMP_EQ:       cond = (rs2_val == rs1_val);
      ALU_CMP_NE:       cond = (rs2_val != rs1_val);
      ALU_CMP_LT:       cond = (rs2_val < rs1_val); // Unsigned
      ALU_CMP_GE:       cond = (rs2_val >= rs1_val);
      default: ;
    endcase
  end

  always_ff @(posedge pixel_clk_in) begin
    if (rst_in) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
      wb_pending <= 1'b0;
      wr_valid   <= 1'b0;
      taken_q    <= 1'b0;
    end else begin
      if (state == ST_EXECUTE) begin
        wb_pending <= op.writes_reg;
        wr_valid   <= op.writes_sprite;
        taken_q    <= op.is_jal || (op.is_branch && cond);
      end else begin
        wb_pending <= 1'b0;  // Valid for the WRITEBACK cycle only
        wr_valid   <= 1'b0;
        taken_q    <= 1'b0;
      end
      if (state == ST_WRITEBACK && wb_pending) begin
        regs[wb_rd] <= res_q;
      end
    end
  end

  always_ff @(posedge pixel_clk_in) begin
    if (state == ST_EXECUTE) begin
      wb_rd     <= op.rd;
      wr_sprite <= op.sprite;
      wr_attr   <= op.attr;
      res_q     <= result;
      target_q  <= op.target;
    end
  end

  assign sprite_wr = '{valid: wr_valid, sprite: wr_sprite, attr: wr_attr, data: res_q};
  assign redirect  = '{taken: taken_q, target: target_q};

endmodule

`default_nettype wire

// File: hw/sprite_slot.sv
`timescale 1ns/1ps
`default_nettype none

module sprite_slot import game_pkg::*; #(
  parameter int SLOT_ID = 0
) (
  input  wire             pixel_clk_in,
  input  wire             rst_in,
  input  wire sprite_wr_t sprite_wr,
  output sprite_attrs_t   attrs
);

  logic hit;

  // Broadcast write, each slot picks its own
  assign hit = sprite_wr.valid && (sprite_wr.sprite == sprite_idx_t'(SLOT_ID));

  always_ff @(posedge pixel_clk_in) begin
    if (rst_in) begin
      attrs <= '0;
    end else if (hit) begin
      attrs[sprite_wr.attr] <= sprite_wr.data;
    end
  end

endmodule

`default_nettype wire

// File: hw/frame_scanner.sv
`timescale 1ns/1ps
`default_nettype none

module frame_scanner import game_pkg::*; (
  input  wire                pixel_clk_in,
  input  wire                rst_in,
  input  wire                new_frame,
  input  wire sprite_attrs_t slot_attrs [NUM_SPRITES],
  output coord_x_t           x,
  output coord_y_t           y,
  output frame_t             frame,
  output logic               sprite_valid
);

  logic          start_q;
  logic          active;
  sprite_idx_t   idx;
  sprite_attrs_t cur;
  logic          alive;

  assign cur   = slot_attrs[idx];
  assign alive = (cur[ATTR_HEALTH] != '0);

  always_ff @(posedge pixel_clk_in) begin
    if (rst_in) begin
      start_q      <= 1'b0;
      active       <= 1'b0;
      idx          <= '0;
      sprite_valid <= 1'b0;
    end else begin
      start_q <= new_frame;
      if (start_q) begin
        idx    <= '0; // Restart also mid-scan
        active <= 1'b1;
      end else if (active) begin
        idx <= idx + 1'b1;
        if (idx == sprite_idx_t'(NUM_SPRITES - 1)) active <= 1'b0;
      end
      sprite_valid <= active && alive;
    end
  end

  always_ff @(posedge pixel_clk_in) begin
    if (active && alive) begin
      x     <= coord_x_t'(cur[ATTR_X]);
      y     <= coord_y_t'(cur[ATTR_Y]);
      frame <= frame_t'(cur[ATTR_FRAME]);
    end
  end

endmodule

`default_nettype wire

// File: hw/sprite_engine_top.sv
`timescale 1ns/1ps
`default_nettype none

module sprite_engine_top import game_pkg::*; (
  input  wire         pixel_clk_in,
  input  wire         rst_in,
  input  wire         new_frame,
  input  wire         instr_ack,
  input  wire instr_t instr_data,
  output wire         instr_req,
  output wire pc_t    instr_addr,
  output wire         done,
  output coord_x_t    x,
  output coord_y_t    y,
  output frame_t      frame,
  output wire         sprite_valid
);

  instr_t        instr;
  pc_t           pc;
  core_state_e   state;
  dec_op_t       op;
  redirect_t     redirect;
  sprite_wr_t    sprite_wr;
  sprite_attrs_t slot_attrs [NUM_SPRITES];

  fetch_ctrl u_fetch (
    .pixel_clk_in (pixel_clk_in),
    .rst_in       (rst_in),
    .instr_ack    (instr_ack),
    .instr_data   (instr_data),
    .redirect     (redirect),
    .instr_req    (instr_req),
    .instr_addr   (instr_addr),
    .instr        (instr),
    .pc           (pc),
    .state        (state),
    .done         (done)
  );

  instr_decode u_decode (
    .instr (instr),
    .op    (op)
  );

  exec_unit u_exec (
    .pixel_clk_in (pixel_clk_in),
    .rst_in       (rst_in),
    .state        (state),
    .op           (op),
    .pc           (pc),
    .slot_attrs   (slot_attrs),
    .redirect     (redirect),
    .sprite_wr    (sprite_wr)
  );

  for (genvar i = 0; i < NUM_SPRITES; i++) begin : g_slot
    sprite_slot #(.SLOT_ID(i)) u_slot (
      .pixel_clk_in (pixel_clk_in),
      .rst_in       (rst_in),
      .sprite_wr    (sprite_wr),
      .attrs        (slot_attrs[i])
    );
  end

  frame_scanner u_scanner (
    .pixel_clk_in (pixel_clk_in),
    .rst_in       (rst_in),
    .new_frame    (new_frame),
    .slot_attrs   (slot_attrs),
    .x            (x),
    .y            (y),
    .frame        (frame),
    .sprite_valid (sprite_valid)
  );

endmodule

`default_nettype wire

// File: tests/tb_ref_model.svh
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// Ack delay of 0 to 3 cycles
function automatic int lcg_next();
  lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
  return int'(lcg_state[25:24]);
endfunction

function automatic instr_t enc_li(reg_idx_t rd, logic [19:0] v);
  return {4'b0, v, rd, 7'h37};
endfunction

function automatic instr_t enc_regimm(logic [2:0] f, reg_idx_t rd, reg_idx_t rs1,
                                      logic [11:0] imm);
  return {4'b0, imm, rs1, f, rd, 7'h13};
endfunction

function automatic instr_t enc_regreg(logic [6:0] f7, reg_idx_t rd, reg_idx_t rs1,
                                      reg_idx_t rs2);
  return {4'b0, f7, rs2, rs1, 3'b0, rd, 7'h33};
endfunction

function automatic instr_t enc_spli(sprite_idx_t s, attr_idx_t a, logic [18:0] v);
  return {a, 1'b1, v, 2'b0, s, 7'h37};
endfunction

function automatic instr_t enc_spaddi(sprite_idx_t s, attr_idx_t a, reg_idx_t rs1,
                                      logic [11:0] imm);
  return {a, 1'b1, imm, rs1, 4'b0, s, 7'h13};
endfunction

function automatic instr_t enc_spsub(sprite_idx_t s, attr_idx_t a, reg_idx_t rs1);
  return {a, 1'b1, 7'h20, 5'b0, rs1, 4'b0, s, 7'h33};
endfunction

function automatic instr_t enc_lisp(reg_idx_t rd, sprite_idx_t s, attr_idx_t a);
  return {a, 1'b1, 12'b0, 2'b0, s, 2'b0, rd, 7'h3F};
endfunction

// Target bit 5 sits in instruction bit 25, the rest in bits 11 to 7
function automatic instr_t enc_branch(logic [2:0] f, reg_idx_t rs1, reg_idx_t rs2, pc_t t);
  return {4'b0, 6'b0, t[5], rs2, rs1, f, t[4:0], 7'h63};
endfunction

function automatic instr_t enc_jal(reg_idx_t rd, pc_t t);
  return {4'b0, 14'b0, t, rd, 7'h6F};
endfunction

// Interprets prog from address 0 until the pc reaches PROGRAM_LEN
function automatic void run_reference();
  word_t  r [NUM_REGS];
  int     pc;
  int     npc;
  int     steps;
  instr_t i;
  logic   tk;
  word_t  a;
  for (int k = 0; k < NUM_REGS; k++) r[k] = '0;
  for (int s = 0; s < NUM_SPRITES; s++) begin
    for (int t = 0; t < NUM_ATTRS; t++) exp_sp[s][t] = '0;
  end
  exp_trace.delete();
  pc = 0;
  steps = 0;
  while (pc != PROGRAM_LEN && steps < 4096) begin
    i = prog[pc];
    exp_trace.push_back(pc_t'(pc)); // Fetch order
    npc = pc + 1;
    steps++;
    case ({i[32], i[6:0]})
      8'h37: r[i[11:7]] = 32'(i[31:12]);
      8'h13: begin
        if (i[14:12] == 3'd0) r[i[11:7]] = r[i[19:15]] + 32'(i[31:20]);
        else if (i[14:12] == 3'd1) r[i[11:7]] = r[i[19:15]] - 32'(i[31:20]);
      end
      8'h33: begin
        if (i[31:25] == 7'd0) r[i[11:7]] = r[i[19:15]] + r[i[24:20]];
        else if (i[31:25] == 7'd1) begin
          r[i[11:7]] = (r[i[19:15]] < r[i[24:20]]) ? '0 : r[i[19:15]] - r[i[24:20]];
        end
      end
      8'hB7: exp_sp[i[10:7]][i[35:33]] = 32'(i[31:13]);
      8'h93: if (i[14:13] == 2'd0) exp_sp[i[10:7]][i[35:33]] = r[i[19:15]] + 32'(i[31:20]);
      8'hB3: begin
        if (i[31:25] == 7'h20) begin
          a = exp_sp[i[10:7]][i[35:33]];
          exp_sp[i[10:7]][i[35:33]] = (a < r[i[19:15]]) ? '0 : a - r[i[19:15]];
        end
      end
      8'hBF: r[i[11:7]] = exp_sp[i[17:14]][i[35:33]];
      8'h63: begin
        case (i[14:12])
          3'd0: tk = (r[i[24:20]] == r[i[19:15]]);
          3'd1: tk = (r[i[24:20]] != r[i[19:15]]);
          3'd4: tk = (r[i[24:20]] < r[i[19:15]]);
          3'd5: tk = (r[i[24:20]] >= r[i[19:15]]);
          default: tk = 1'b0;
        endcase
        if (tk) npc = int'(pc_t'({i[31:25], i[11:7]}));
      end
      8'h6F: begin
        r[i[11:7]] = 32'(pc + 1);
        npc = int'(pc_t'(i[31:12]));
      end
      default: ;
    endcase
    pc = npc;
  end
endfunction

`endif

// File: tests/tb_sprite_engine.sv
`timescale 1ns/1ps
`default_nettype none

module tb_sprite_engine import game_pkg::*; ();

  localparam int CLK_PERIOD = 40;
  localparam int NUM_RUNS   = 4;
  localparam int NUM_SCANS  = 6;
  localparam int TIMEOUT_NS = (NUM_RUNS * PROGRAM_LEN * 12 + NUM_SCANS * 40 + 200) * CLK_PERIOD;

  logic     pixel_clk_in;
  logic     rst_in;
  logic     new_frame;
  logic     instr_ack;
  instr_t   instr_data;
  wire      instr_req;
  pc_t      instr_addr;
  wire      done;
  coord_x_t x;
  coord_y_t y;
  frame_t   frame;
  wire      sprite_valid;

  instr_t      prog [PROGRAM_LEN];
  word_t       exp_sp [NUM_SPRITES][NUM_ATTRS];
  pc_t         exp_trace [$];
  logic [31:0] lcg_state;
  int          scan_pos = -1;  // Edges since new_frame was sampled
  int          scans_done = 0;

  `include "tb_ref_model.svh"

  sprite_engine_top DUT (
    .pixel_clk_in (pixel_clk_in),
    .rst_in       (rst_in),
    .new_frame    (new_frame),
    .instr_ack    (instr_ack),
    .instr_data   (instr_data),
    .instr_req    (instr_req),
    .instr_addr   (instr_addr),
    .done         (done),
    .x            (x),
    .y            (y),
    .frame        (frame),
    .sprite_valid (sprite_valid)
  );

  initial begin
    pixel_clk_in = 1'b0;
    forever #(CLK_PERIOD / 2) pixel_clk_in = ~pixel_clk_in;
  end

  task automatic report_failure();
    $display("Verification failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_valid(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("Error: %s got 0x%h expected 0x%h", name, got, exp);
      report_failure();
    end
  endtask

  task automatic check_addr(pc_t got, pc_t exp);
    if (got !== exp) begin
      $display("Error: instr_addr got 0x%h expected 0x%h", got, exp);
      report_failure();
    end
  endtask

  task automatic check_x(coord_x_t got, coord_x_t exp);
    if (got !== exp) begin
      $display("Error: x got 0x%h expected 0x%h", got, exp);
      report_failure();
    end
  endtask

  task automatic check_y(coord_y_t got, coord_y_t exp);
    if (got !== exp) begin
      $display("Error: y got 0x%h expected 0x%h", got, exp);
      report_failure();
    end
  endtask

  task automatic check_frame(frame_t got, frame_t exp);
    if (got !== exp) begin
      $display("Error: frame got 0x%h expected 0x%h", got, exp);
      report_failure();
    end
  endtask

  // Fetch responder, four-phase
  initial begin
    int   delay;
    pc_t  addr;
    forever begin
      @(negedge pixel_clk_in);
      if (instr_req && !instr_ack && !rst_in) begin
        addr = instr_addr;
        if (exp_trace.size() == 0) begin
          $display("Fetch from 0x%h after the reference program had ended", addr);
          report_failure();
        end else begin
          check_addr(addr, exp_trace.pop_front());
        end
        delay = lcg_next();
        repeat (delay) @(posedge pixel_clk_in);
        @(posedge pixel_clk_in);
        instr_data <= prog[addr];
        instr_ack  <= 1'b1;
        do @(negedge pixel_clk_in); while (instr_req);
        @(posedge pixel_clk_in);
        instr_ack <= 1'b0;
      end
    end
  end

  always @(posedge pixel_clk_in) begin
    if (new_frame) scan_pos <= 0;
    else if (scan_pos >= 0 && scan_pos < 18) scan_pos <= scan_pos + 1;
    else scan_pos <= -1;
  end

  // Slot i shows up 2+i edges after new_frame is sampled
  always @(negedge pixel_clk_in) begin
    logic ev;
    int   s;
    if (scan_pos >= 2 && scan_pos <= 17) begin
      s = scan_pos - 2;
      ev = (exp_sp[s][ATTR_HEALTH] != '0);
      check_valid("sprite_valid", sprite_valid, ev);
      if (ev) begin
        check_x(x, coord_x_t'(exp_sp[s][ATTR_X]));
        check_y(y, coord_y_t'(exp_sp[s][ATTR_Y]));
        check_frame(frame, frame_t'(exp_sp[s][ATTR_FRAME]));
      end
    end else if (scan_pos == 18) begin
      check_valid("sprite_valid", sprite_valid, 1'b0);
      scans_done++;
    end
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Verification failed");
    $fatal(1, "Timeout, the DUT did not finish the programs and scans in time");
  end

  task automatic apply_reset();
    @(posedge pixel_clk_in);
    rst_in <= 1'b1;
    repeat (4) @(posedge pixel_clk_in);
    rst_in <= 1'b0;
  endtask

  task automatic run_scan(bit restart);
    int target;
    target = scans_done + 1;
    @(posedge pixel_clk_in);
    new_frame <= 1'b1;
    @(posedge pixel_clk_in);
    new_frame <= 1'b0;
    if (restart) begin
      repeat (6) @(posedge pixel_clk_in);
      new_frame <= 1'b1;
      @(posedge pixel_clk_in);
      new_frame <= 1'b0;
    end
    do @(negedge pixel_clk_in); while (scans_done != target);
  endtask

  task automatic load_program(int n);
    for (int a = 0; a < PROGRAM_LEN; a++) begin
      prog[a] = {4'b0, 19'b0, 6'(a), 7'h0B}; // No-op carrying its address
    end
    case (n)
      1: begin
        prog[0]  = enc_spli(1, ATTR_HEALTH, 5);
        prog[1]  = enc_spli(1, ATTR_X, 100);
        prog[2]  = enc_spli(1, ATTR_Y, 50);
        prog[3]  = enc_spli(1, ATTR_FRAME, 3);
        prog[4]  = enc_spli(4, ATTR_HEALTH, 1);
        prog[5]  = enc_spli(4, ATTR_X, 319);
        prog[6]  = enc_spli(4, ATTR_Y, 179);
        prog[7]  = enc_spli(4, ATTR_FRAME, 7);
        prog[8]  = enc_spli(9, ATTR_X, 77);  // Health stays zero
        prog[9]  = enc_spli(15, ATTR_HEALTH, 2);
        prog[10] = enc_spli(15, ATTR_X, 600);
        prog[11] = enc_spli(15, ATTR_Y, 300);
      end
      2: begin
        prog[0]  = enc_li(1, 40);
        prog[1]  = enc_regimm(0, 2, 1, 25);
        prog[2]  = enc_regimm(1, 3, 1, 50);  // Wraps
        prog[3]  = enc_regreg(0, 4, 1, 2);
        prog[4]  = enc_regreg(1, 5, 1, 2);   // Floored
        prog[5]  = enc_regreg(1, 6, 2, 1);
        prog[6]  = enc_spli(2, ATTR_HEALTH, 10);
        prog[7]  = enc_spaddi(2, ATTR_X, 4, 0);
        prog[8]  = enc_spaddi(2, ATTR_Y, 6, 7);
        prog[9]  = enc_spaddi(2, ATTR_FRAME, 5, 5);
        prog[10] = enc_spli(3, ATTR_HEALTH, 20);
        prog[11] = enc_spli(3, ATTR_X, 9);
        prog[12] = enc_spsub(3, ATTR_HEALTH, 1); // Health floors to zero
        prog[13] = enc_spli(5, ATTR_HEALTH, 100);
        prog[14] = enc_spsub(5, ATTR_HEALTH, 6);
        prog[15] = enc_spaddi(5, ATTR_X, 3, 0);
        prog[16] = enc_spaddi(5, ATTR_Y, 2, 0);
      end
      3: begin
        prog[0]  = enc_li(1, 5);
        prog[1]  = enc_li(2, 7);
        prog[2]  = enc_branch(0, 1, 2, 4);
        prog[3]  = enc_spli(0, ATTR_HEALTH, 1);
        prog[4]  = enc_branch(1, 1, 2, 6);
        prog[5]  = enc_spli(8, ATTR_HEALTH, 1);  // Skipped ones wake an idle sprite
        prog[6]  = enc_branch(4, 1, 2, 8);
        prog[7]  = enc_spli(0, ATTR_X, 11);
        prog[8]  = enc_branch(5, 1, 2, 10);
        prog[9]  = enc_spli(9, ATTR_HEALTH, 1);
        prog[10] = enc_branch(4, 2, 1, 12);
        prog[11] = enc_spli(10, ATTR_HEALTH, 1);
        prog[12] = enc_branch(5, 2, 1, 14);
        prog[13] = enc_spli(0, ATTR_Y, 22);
        prog[14] = enc_branch(0, 1, 1, 16);
        prog[15] = enc_spli(11, ATTR_HEALTH, 1);
        prog[16] = enc_branch(1, 1, 1, 18);
        prog[17] = enc_spli(0, ATTR_FRAME, 2);
        prog[18] = enc_li(4, 3);
        prog[19] = enc_regimm(0, 3, 3, 1);
        prog[20] = enc_branch(4, 4, 3, 19);  // Loop until r3 reaches r4
        prog[21] = enc_spli(6, ATTR_HEALTH, 1);
        prog[22] = enc_spaddi(6, ATTR_X, 3, 10);
        prog[23] = enc_jal(5, 26);
        prog[24] = enc_spli(12, ATTR_HEALTH, 1);
        prog[25] = enc_spli(13, ATTR_HEALTH, 1);
        prog[26] = enc_lisp(7, 0, ATTR_X);
        prog[27] = enc_spaddi(6, ATTR_Y, 5, 0);  // Link address
        prog[28] = enc_spaddi(6, ATTR_FRAME, 7, 0);
      end
      default: ;
    endcase
  endtask

  initial begin
    lcg_state  = 32'h9d32;
    rst_in     = 1'b1;
    new_frame  = 1'b0;
    instr_ack  = 1'b0;
    instr_data = '0;
    load_program(0);
    run_reference();
    repeat (4) @(posedge pixel_clk_in);
    rst_in <= 1'b0;
    @(negedge pixel_clk_in);
    check_valid("instr_req", instr_req, 1'b0);
    check_valid("done", done, 1'b0);
    run_scan(1'b0);

    for (int run = 1; run <= NUM_RUNS; run++) begin
      apply_reset();
      load_program(run > 3 ? 3 : run);
      run_reference();
      do @(negedge pixel_clk_in); while (!done);
      check_valid("instr_req", instr_req, 1'b0);
      if (exp_trace.size() != 0) begin
        $display("Core halted with %0d reference fetches still open", exp_trace.size());
        report_failure();
      end
      run_scan(run == NUM_RUNS);
    end

    $display("Verification passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+tests
common/game_pkg.sv
core/fetch_ctrl.sv
core/instr_decode.sv
core/exec_unit.sv
hw/sprite_slot.sv
hw/frame_scanner.sv
hw/sprite_engine_top.sv
tests/tb_sprite_engine.sv

// File: Bender.yml
package:
  name: sprite_engine

sources:
  - common/game_pkg.sv
  - core/fetch_ctrl.sv
  - core/instr_decode.sv
  - core/exec_unit.sv
  - hw/sprite_slot.sv
  - hw/frame_scanner.sv
  - hw/sprite_engine_top.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_sprite_engine.sv
